/* compile.f */
+incdir+logic
logic/oq_pkg.sv
logic/pkt_buffer.sv
logic/pifo_calendar.sv
logic/dequeue_fsm.sv
logic/output_queue.sv
tests/output_queue_props.sv
tests/output_queue_tb.sv

/* tests/output_queue_tb.sv */
`timescale 1ns/1ps
`include "oq_defs.svh"

module output_queue_tb;
    import oq_pkg::*;

    localparam int RANK_W      = `OQ_RANK_W;
    localparam int TAG_W       = `OQ_TAG_W;
    localparam int N_GROUPS    = 5;
    localparam int CREDIT_WAIT = 200;
    localparam int DRAIN_LIMIT = 4000;
    localparam int IDLE_LIMIT  = 40;

    // one row per packet, rows of a group go out together
    typedef struct
    {
        int grp;
        int len;
        int rank;
        int tag;
        bit rnd;
    } stim_t;

    logic                  axis_aclk;
    logic                  axis_resetn;
    logic [`OQ_DATA_W-1:0] s_axis_tdata;
    logic [`OQ_KEEP_W-1:0] s_axis_tkeep;
    logic                  s_axis_tlast;
    pifo_word_u            s_axis_tpifo;
    logic                  s_axis_tvalid;
    logic                  m_axis_tready;
    logic                  m_axis_tvalid;
    logic [`OQ_DATA_W-1:0] m_axis_tdata;
    logic [`OQ_KEEP_W-1:0] m_axis_tkeep;
    logic                  m_axis_tlast;
    pifo_word_u            m_axis_tpifo;
    logic                  credit_return;
    logic [`OQ_ADDR_W:0]   buffer_count;

    stim_t                 stim_q[$];
    string                 group_name [N_GROUPS];

    // expected words, output order
    logic [`OQ_DATA_W-1:0] exp_data[$];
    logic [`OQ_KEEP_W-1:0] exp_keep[$];
    logic                  exp_last[$];
    logic [`OQ_PIFO_W-1:0] exp_pifo[$];
    // words taken off the output
    logic [`OQ_DATA_W-1:0] got_data[$];
    logic [`OQ_KEEP_W-1:0] got_keep[$];
    logic                  got_last[$];
    logic [`OQ_PIFO_W-1:0] got_pifo[$];

    int                    checks;
    int                    errors;
    bit                    timed_out;
    // sender side credit bookkeeping
    int                    words_sent;
    int                    credit_pulses;
    logic [31:0]           lcg_state;

    output_queue u_output_queue (
        .axis_aclk(axis_aclk), .axis_resetn(axis_resetn),
        .s_axis_tdata(s_axis_tdata), .s_axis_tkeep(s_axis_tkeep),
        .s_axis_tlast(s_axis_tlast), .s_axis_tpifo(s_axis_tpifo),
        .s_axis_tvalid(s_axis_tvalid),
        .m_axis_tready(m_axis_tready), .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tdata(m_axis_tdata), .m_axis_tkeep(m_axis_tkeep),
        .m_axis_tlast(m_axis_tlast), .m_axis_tpifo(m_axis_tpifo),
        .credit_return(credit_return), .buffer_count(buffer_count)
    );

    initial
    begin
        axis_aclk = 1'b0;
        forever #10 axis_aclk = ~axis_aclk;
    end

    // credits come back one per pulse
    always @(posedge axis_aclk)
    begin
        if (!axis_resetn)
            credit_pulses <= 0;
        else if (credit_return)
            credit_pulses <= credit_pulses + 1;
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bit random_bit();
        logic [31:0] v;
        v = lcg_next();
        return v[20];
    endfunction

    function automatic void add_pkt(input int grp, input int len, input int rank,
                                    input int tag, input bit rnd);
        stim_t s;
        s.grp  = grp;
        s.len  = len;
        s.rank = rank;
        s.tag  = tag;
        s.rnd  = rnd;
        stim_q.push_back(s);
    endfunction

    // payload built from packet row and word index
    function automatic logic [31:0] data_of(input int row, input int w);
        return {8'h5a ^ 8'(row), 8'(row), 8'(w), 8'(row * 13 + w * 7)};
    endfunction

    // partial keep on the last word only
    function automatic logic [`OQ_KEEP_W-1:0] keep_of(input int row, input int w);
        if (w == stim_q[row].len - 1)
            return 4'hf >> (row % 4);
        return 4'hf;
    endfunction

    function automatic logic [`OQ_PIFO_W-1:0] tpifo_of(input int row);
        return {RANK_W'(stim_q[row].rank), TAG_W'(stim_q[row].tag)};
    endfunction

    task automatic load_table();
        // single packet
        add_pkt(0, 3, 100, 7, 0);
        // ties at 10 and 40
        add_pkt(1, 3, 40, 1, 0);
        add_pkt(1, 1, 10, 2, 0);
        add_pkt(1, 5, 40, 3, 0);
        add_pkt(1, 2, 5, 4, 0);
        add_pkt(1, 4, 10, 5, 0);
        add_pkt(1, 2, 40, 6, 0);
        // random tready and input gaps
        add_pkt(2, 4, 300, 9, 1);
        add_pkt(2, 2, 50, 10, 1);
        add_pkt(2, 6, 300, 11, 1);
        add_pkt(2, 1, 0, 12, 1);
        add_pkt(2, 3, 50, 13, 1);
        // exactly 32 words
        add_pkt(3, 1, 300, 0, 0);
        add_pkt(3, 4, 12, 1, 0);
        add_pkt(3, 1, 12, 2, 0);
        add_pkt(3, 7, 700, 3, 0);
        add_pkt(3, 1, 5, 4, 0);
        add_pkt(3, 3, 300, 5, 0);
        add_pkt(3, 8, 12, 6, 0);
        add_pkt(3, 1, 2047, 7, 0);
        add_pkt(3, 6, 0, 8, 0);
        // freed words reused
        add_pkt(4, 2, 9, 20, 1);
        add_pkt(4, 5, 3, 21, 1);
        add_pkt(4, 1, 9, 22, 1);
        group_name[0] = "single packet";
        group_name[1] = "rank order and ties";
        group_name[2] = "random tready";
        group_name[3] = "full buffer";
        group_name[4] = "reuse after fill";
    endtask

    //////////////////////////////
    // expected order
    //////////////////////////////

    task automatic build_expected(input int g, output int n_words);
        int order[$];
        int tmp;
        int j;
        exp_data.delete();
        exp_keep.delete();
        exp_last.delete();
        exp_pifo.delete();
        foreach (stim_q[i])
        begin
            if (stim_q[i].grp == g)
                order.push_back(i);
        end
        // insertion sort, strict compare keeps ties in arrival order
        for (int i = 1; i < order.size(); i++)
        begin
            tmp = order[i];
            j = i - 1;
            while (j >= 0 && stim_q[order[j]].rank > stim_q[tmp].rank)
            begin
                order[j + 1] = order[j];
                j--;
            end
            order[j + 1] = tmp;
        end
        foreach (order[k])
        begin
            for (int w = 0; w < stim_q[order[k]].len; w++)
            begin
                exp_data.push_back(data_of(order[k], w));
                exp_keep.push_back(keep_of(order[k], w));
                exp_last.push_back(w == stim_q[order[k]].len - 1);
                exp_pifo.push_back(tpifo_of(order[k]));
            end
        end
        n_words = exp_data.size();
    endtask

    //////////////////////////////
    // drive and collect
    //////////////////////////////

    task automatic send_packet(input int row);
        int waited;
        for (int w = 0; w < stim_q[row].len; w++)
        begin
            @(posedge axis_aclk);
            if (stim_q[row].rnd && random_bit())
            begin
                s_axis_tvalid <= 1'b0;
                @(posedge axis_aclk);
            end
            // hold off until a credit is in hand
            waited = 0;
            while (words_sent - credit_pulses >= `OQ_BUF_DEPTH && waited < CREDIT_WAIT)
            begin
                s_axis_tvalid <= 1'b0;
                @(posedge axis_aclk);
                waited++;
            end
            if (words_sent - credit_pulses >= `OQ_BUF_DEPTH)
            begin
                $display("no credit came back for packet %0d after %0d cycles", row, waited);
                errors++;
                timed_out = 1'b1;
                return;
            end
            s_axis_tvalid <= 1'b1;
            s_axis_tdata  <= data_of(row, w);
            s_axis_tkeep  <= keep_of(row, w);
            s_axis_tlast  <= (w == stim_q[row].len - 1);
            // later words carry junk tpifo, only the first counts
            s_axis_tpifo  <= (w == 0) ? tpifo_of(row) : ~tpifo_of(row);
            words_sent++;
        end
    endtask

    task automatic drain_output(input int n_words, input bit random_ready);
        int cycles;
        cycles = 0;
        while (got_data.size() < n_words && cycles < DRAIN_LIMIT)
        begin
            @(posedge axis_aclk);
            if (m_axis_tvalid && m_axis_tready)
            begin
                got_data.push_back(m_axis_tdata);
                got_keep.push_back(m_axis_tkeep);
                got_last.push_back(m_axis_tlast);
                got_pifo.push_back(m_axis_tpifo);
            end
            m_axis_tready <= random_ready ? random_bit() : 1'b1;
            cycles++;
        end
        m_axis_tready <= 1'b0;
        if (got_data.size() < n_words)
        begin
            $display("output stalled, %0d of %0d words after %0d cycles",
                     got_data.size(), n_words, cycles);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    //////////////////////////////
    // one group, load then drain
    //////////////////////////////

    task automatic run_group(input int g);
        int first_err;
        int start_pulses;
        int start_sent;
        int n_words;
        int waited;
        bit random_ready;
        first_err    = errors;
        start_pulses = credit_pulses;
        start_sent   = words_sent;
        random_ready = 1'b0;
        build_expected(g, n_words);
        got_data.delete();
        got_keep.delete();
        got_last.delete();
        got_pifo.delete();
        // tready stays low, whole group sits in the calendar
        foreach (stim_q[i])
        begin
            if (stim_q[i].grp == g && !timed_out)
            begin
                random_ready = stim_q[i].rnd;
                send_packet(i);
            end
        end
        @(posedge axis_aclk);
        s_axis_tvalid <= 1'b0;
        s_axis_tlast  <= 1'b0;
        if (!timed_out)
            drain_output(n_words, random_ready);

        // last accepted word leaves the output reg on this edge
        @(posedge axis_aclk);
        // occupancy falls the edge after the last credit
        waited = 0;
        while (buffer_count != 0 && waited < IDLE_LIMIT)
        begin
            @(posedge axis_aclk);
            waited++;
        end

        checks++;
        if (got_data.size() != n_words)
        begin
            $display("ERROR output word count got 0x%h exp 0x%h", got_data.size(), n_words);
            errors++;
        end
        for (int i = 0; i < got_data.size() && i < n_words; i++)
        begin
            checks += 4;
            if (got_data[i] !== exp_data[i])
            begin
                $display("ERROR m_axis_tdata word %0d got 0x%h exp 0x%h", i, got_data[i],
                         exp_data[i]);
                errors++;
            end
            if (got_keep[i] !== exp_keep[i])
            begin
                $display("ERROR m_axis_tkeep word %0d got 0x%h exp 0x%h", i, got_keep[i],
                         exp_keep[i]);
                errors++;
            end
            if (got_last[i] !== exp_last[i])
            begin
                $display("ERROR m_axis_tlast word %0d got 0x%h exp 0x%h", i, got_last[i],
                         exp_last[i]);
                errors++;
            end
            if (got_pifo[i] !== exp_pifo[i])
            begin
                $display("ERROR m_axis_tpifo word %0d got 0x%h exp 0x%h", i, got_pifo[i],
                         exp_pifo[i]);
                errors++;
            end
        end

        checks += 3;
        if (credit_pulses - start_pulses != words_sent - start_sent)
        begin
            $display("ERROR credit_return pulses got 0x%h exp 0x%h",
                     credit_pulses - start_pulses, words_sent - start_sent);
            errors++;
        end
        if (buffer_count !== 0)
        begin
            $display("ERROR buffer_count got 0x%h exp 0x%h", buffer_count, 0);
            errors++;
        end
        // nothing left over, no duplicate waiting on the output
        if (m_axis_tvalid !== 1'b0)
        begin
            $display("ERROR m_axis_tvalid got 0x%h exp 0x%h", m_axis_tvalid, 1'b0);
            errors++;
        end

        $display("test %0d %s: %s, %0d words in, %0d out", g, group_name[g],
                 (errors == first_err) ? "ok" : "failed", words_sent - start_sent,
                 got_data.size());
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        axis_resetn   = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tlast  = 1'b0;
        s_axis_tpifo  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        lcg_state     = 32'h9fd7_a9f1;
        checks        = 0;
        errors        = 0;
        timed_out     = 1'b0;
        words_sent    = 0;
        load_table();

        repeat (3) @(posedge axis_aclk);
        axis_resetn <= 1'b1;
        @(posedge axis_aclk);
        checks++;
        if (m_axis_tvalid !== 1'b0)
        begin
            $display("ERROR m_axis_tvalid after reset got 0x%h exp 0x%h", m_axis_tvalid, 1'b0);
            errors++;
        end

        for (int g = 0; g < N_GROUPS; g++)
        begin
            if (!timed_out)
                run_group(g);
        end

        // bound assertions of the last edge have run by now
        @(posedge axis_aclk);
        checks++;
        if (u_output_queue.u_output_queue_props.fail_count != 0)
        begin
            $display("bound assertions failed %0d times",
                     u_output_queue.u_output_queue_props.fail_count);
            errors++;
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* tests/output_queue_props.sv */
`timescale 1ns/1ps
`include "oq_defs.svh"

module output_queue_props (
    input logic                  axis_aclk,
    input logic                  axis_resetn,
    input logic                  m_axis_tvalid,
    input logic                  m_axis_tready,
    input logic [`OQ_DATA_W-1:0] m_axis_tdata,
    input logic [`OQ_KEEP_W-1:0] m_axis_tkeep,
    input logic                  m_axis_tlast,
    input oq_pkg::pifo_word_u    m_axis_tpifo,
    input logic                  credit_return,
    input logic [`OQ_ADDR_W:0]   buffer_count
);

    // failed assertions so far
    int fail_count;

    //////////////////////////////
    // output stream
    //////////////////////////////

    // stalled word holds until taken
    a_hold_stalled: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (m_axis_tvalid && !m_axis_tready) |=>
            (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tkeep) &&
             $stable(m_axis_tlast) && $stable(m_axis_tpifo)))
        else
        begin
            fail_count++;
            $error("output word changed while stalled");
        end

    // quiet output right after reset
    a_reset_idle: assert property (@(posedge axis_aclk)
        !axis_resetn |=> !m_axis_tvalid)
        else
        begin
            fail_count++;
            $error("m_axis_tvalid high after reset");
        end

    //////////////////////////////
    // buffer occupancy
    //////////////////////////////

    // a freed word must have been held
    a_credit_held: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        credit_return |-> buffer_count != 0)
        else
        begin
            fail_count++;
            $error("credit returned with an empty buffer");
        end

    a_count_bound: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        buffer_count <= `OQ_BUF_DEPTH)
        else
        begin
            fail_count++;
            $error("buffer_count above buffer depth");
        end

endmodule

bind output_queue output_queue_props u_output_queue_props (
    .axis_aclk(axis_aclk), .axis_resetn(axis_resetn),
    .m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready),
    .m_axis_tdata(m_axis_tdata), .m_axis_tkeep(m_axis_tkeep),
    .m_axis_tlast(m_axis_tlast), .m_axis_tpifo(m_axis_tpifo),
    .credit_return(credit_return), .buffer_count(buffer_count)
);

/* logic/output_queue.sv */
`timescale 1ns/1ps
`include "oq_defs.svh"

module output_queue (
    input  logic                  axis_aclk,
    input  logic                  axis_resetn,
    // input stream, credit flow control
    input  logic [`OQ_DATA_W-1:0] s_axis_tdata,
    input  logic [`OQ_KEEP_W-1:0] s_axis_tkeep,
    input  logic                  s_axis_tlast,
    input  oq_pkg::pifo_word_u    s_axis_tpifo,
    input  logic                  s_axis_tvalid,
    // output stream
    input  logic                  m_axis_tready,
    output logic                  m_axis_tvalid,
    output logic [`OQ_DATA_W-1:0] m_axis_tdata,
    output logic [`OQ_KEEP_W-1:0] m_axis_tkeep,
    output logic                  m_axis_tlast,
    output oq_pkg::pifo_word_u    m_axis_tpifo,
    // one pulse per freed word
    output logic                  credit_return,
    output logic [`OQ_ADDR_W:0]   buffer_count
);

    //////////////////////////////
    // internal wires
    //////////////////////////////

    // buffer to calendar
    logic                  insert_en;
    oq_pkg::pifo_word_u    insert_word;
    // calendar to dequeue
    logic                  pop_en;
    logic                  cal_empty;
    oq_pkg::pifo_word_u    head_word;
    // dequeue reads from the buffer
    logic                  rd_en;
    logic [`OQ_ADDR_W-1:0] rd_addr;
    logic [`OQ_DATA_W-1:0] rd_data;
    logic [`OQ_KEEP_W-1:0] rd_keep;
    logic                  rd_last;
    oq_pkg::pifo_word_u    rd_tag;
    logic [`OQ_ADDR_W-1:0] rd_next;

    pkt_buffer u_pkt_buffer (
        .axis_aclk(axis_aclk), .axis_resetn(axis_resetn),
        .s_axis_tdata(s_axis_tdata), .s_axis_tkeep(s_axis_tkeep),
        .s_axis_tlast(s_axis_tlast), .s_axis_tpifo(s_axis_tpifo),
        .s_axis_tvalid(s_axis_tvalid),
        .rd_en(rd_en), .rd_addr(rd_addr),
        .rd_data(rd_data), .rd_keep(rd_keep), .rd_last(rd_last),
        .rd_tag(rd_tag), .rd_next(rd_next),
        .insert_en(insert_en), .insert_word(insert_word),
        .credit_return(credit_return), .buffer_count(buffer_count)
    );

    pifo_calendar u_pifo_calendar (
        .axis_aclk(axis_aclk), .axis_resetn(axis_resetn),
        .insert_en(insert_en), .insert_word(insert_word),
        .pop_en(pop_en), .head_word(head_word), .cal_empty(cal_empty)
    );

    dequeue_fsm u_dequeue_fsm (
        .axis_aclk(axis_aclk), .axis_resetn(axis_resetn),
        .cal_empty(cal_empty), .head_word(head_word),
        .rd_data(rd_data), .rd_keep(rd_keep), .rd_last(rd_last),
        .rd_tag(rd_tag), .rd_next(rd_next),
        .m_axis_tready(m_axis_tready),
        .pop_en(pop_en), .rd_en(rd_en), .rd_addr(rd_addr),
        .m_axis_tvalid(m_axis_tvalid), .m_axis_tdata(m_axis_tdata),
        .m_axis_tkeep(m_axis_tkeep), .m_axis_tlast(m_axis_tlast),
        .m_axis_tpifo(m_axis_tpifo)
    );

endmodule

/* logic/dequeue_fsm.sv */
`timescale 1ns/1ps
`include "oq_defs.svh"

module dequeue_fsm (
    input  logic                  axis_aclk,
    input  logic                  axis_resetn,
    input  logic                  cal_empty,
    input  oq_pkg::pifo_word_u    head_word,
    input  logic [`OQ_DATA_W-1:0] rd_data,
    input  logic [`OQ_KEEP_W-1:0] rd_keep,
    input  logic                  rd_last,
    input  oq_pkg::pifo_word_u    rd_tag,
    input  logic [`OQ_ADDR_W-1:0] rd_next,
    input  logic                  m_axis_tready,
    output logic                  pop_en,
    output logic                  rd_en,
    output logic [`OQ_ADDR_W-1:0] rd_addr,
    output logic                  m_axis_tvalid,
    output logic [`OQ_DATA_W-1:0] m_axis_tdata,
    output logic [`OQ_KEEP_W-1:0] m_axis_tkeep,
    output logic                  m_axis_tlast,
    output oq_pkg::pifo_word_u    m_axis_tpifo
);
    import oq_pkg::*;

    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] POP   = 2'd1;
    localparam logic [1:0] READ  = 2'd2;
    localparam logic [1:0] DRAIN = 2'd3;

    logic [1:0]            state;
    logic [1:0]            state_next;
    // first word of the popped packet
    logic [`OQ_ADDR_W-1:0] sop_q;
    // buffer read regs hold a word not yet taken
    logic                  ret_valid;
    logic                  load;
    logic                  accept;

    assign accept = m_axis_tvalid && m_axis_tready;
    // staged word moves into a free or emptying output reg
    assign load   = ret_valid && (!m_axis_tvalid || m_axis_tready);

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb
    begin
        state_next = state;
        pop_en     = 1'b0;
        rd_en      = 1'b0;
        rd_addr    = rd_next;
        case (state)
            IDLE:
            begin
                if (m_axis_tready && !cal_empty)
                begin
                    pop_en     = 1'b1;
                    state_next = POP;
                end
            end
            POP:
            begin
                // first read of the packet
                rd_en      = 1'b1;
                rd_addr    = sop_q;
                state_next = READ;
            end
            READ:
            begin
                // refill the read regs as the staged word leaves
                if (load)
                begin
                    if (rd_last)
                    begin
                        state_next = DRAIN;
                    end
                    else
                    begin
                        rd_en = 1'b1;
                    end
                end
            end
            DRAIN:
            begin
                if (accept && m_axis_tlast)
                begin
                    state_next = IDLE;
                end
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    //////////////////////////////
    // control regs
    //////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state         <= IDLE;
            ret_valid     <= 1'b0;
            m_axis_tvalid <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (rd_en)
            begin
                ret_valid <= 1'b1;
            end
            else if (load)
            begin
                ret_valid <= 1'b0;
            end
            if (load)
            begin
                m_axis_tvalid <= 1'b1;
            end
            else if (m_axis_tready)
            begin
                m_axis_tvalid <= 1'b0;
            end
        end
    end

    // output word, held while tready is low
    always_ff @(posedge axis_aclk)
    begin
        if (pop_en)
        begin
            sop_q <= head_word.entry_view.addr;
        end
        if (load)
        begin
            m_axis_tdata <= rd_data;
            m_axis_tkeep <= rd_keep;
            m_axis_tlast <= rd_last;
            m_axis_tpifo <= rd_tag;
        end
    end

endmodule

/* logic/pifo_calendar.sv */
`timescale 1ns/1ps
`include "oq_defs.svh"

module pifo_calendar (
    input  logic               axis_aclk,
    input  logic               axis_resetn,
    input  logic               insert_en,
    input  oq_pkg::pifo_word_u insert_word,
    input  logic               pop_en,
    output oq_pkg::pifo_word_u head_word,
    output logic               cal_empty
);
    import oq_pkg::*;

    // slot 0 is the head, valid slots packed at the front
    pifo_word_u               entry      [`OQ_BUF_DEPTH];
    logic [`OQ_BUF_DEPTH-1:0] valid;

    // array after the pop, before the insert
    pifo_word_u               base       [`OQ_BUF_DEPTH];
    logic [`OQ_BUF_DEPTH-1:0] base_valid;

    pifo_word_u               entry_next [`OQ_BUF_DEPTH];
    logic [`OQ_BUF_DEPTH-1:0] valid_next;

    // slots that stay ahead of the new entry
    logic [`OQ_BUF_DEPTH-1:0] rank_le;
    int                       ins_pos;

    //////////////////////////////
    // insert position
    //////////////////////////////

    // equal rank counts as ahead, so ties leave in arrival order
    always_comb
    begin
        for (int i = 0; i < `OQ_BUF_DEPTH; i++)
        begin
            rank_le[i] = valid[i] &&
                         (entry[i].entry_view.rank <= insert_word.entry_view.rank);
        end
    end

    // rank_le is a prefix, first clear bit is the slot
    always_comb
    begin
        ins_pos = `OQ_BUF_DEPTH;
        for (int i = `OQ_BUF_DEPTH - 1; i >= 0; i--)
        begin
            if (!rank_le[i])
            begin
                ins_pos = i;
            end
        end
        // a pop moves everything one slot toward the head
        if (pop_en && ins_pos != 0)
        begin
            ins_pos = ins_pos - 1;
        end
    end

    //////////////////////////////
    // shift network
    //////////////////////////////

    always_comb
    begin
        for (int i = 0; i < `OQ_BUF_DEPTH; i++)
        begin
            if (pop_en && i < `OQ_BUF_DEPTH - 1)
            begin
                base[i]       = entry[i + 1];
                base_valid[i] = valid[i + 1];
            end
            else
            begin
                base[i]       = entry[i];
                base_valid[i] = valid[i] && !pop_en;
            end
        end

        for (int i = 0; i < `OQ_BUF_DEPTH; i++)
        begin
            if (!insert_en || i < ins_pos)
            begin
                entry_next[i] = base[i];
                valid_next[i] = base_valid[i];
            end
            else if (i == ins_pos)
            begin
                entry_next[i] = insert_word;
                valid_next[i] = 1'b1;
            end
            else if (i > 0)
            begin
                // open the gap behind the new entry
                entry_next[i] = base[i - 1];
                valid_next[i] = base_valid[i - 1];
            end
            else
            begin
                entry_next[i] = base[i];
                valid_next[i] = base_valid[i];
            end
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            valid <= '0;
        end
        else
        begin
            valid <= valid_next;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        entry <= entry_next;
    end

    assign head_word = entry[0];
    assign cal_empty = !valid[0];

endmodule

/* logic/pkt_buffer.sv */
`timescale 1ns/1ps
`include "oq_defs.svh"

module pkt_buffer (
    input  logic                  axis_aclk,
    input  logic                  axis_resetn,
    input  logic [`OQ_DATA_W-1:0] s_axis_tdata,
    input  logic [`OQ_KEEP_W-1:0] s_axis_tkeep,
    input  logic                  s_axis_tlast,
    input  oq_pkg::pifo_word_u    s_axis_tpifo,
    input  logic                  s_axis_tvalid,
    input  logic                  rd_en,
    input  logic [`OQ_ADDR_W-1:0] rd_addr,
    output logic [`OQ_DATA_W-1:0] rd_data,
    output logic [`OQ_KEEP_W-1:0] rd_keep,
    output logic                  rd_last,
    output oq_pkg::pifo_word_u    rd_tag,
    output logic [`OQ_ADDR_W-1:0] rd_next,
    output logic                  insert_en,
    output oq_pkg::pifo_word_u    insert_word,
    output logic                  credit_return,
    output logic [`OQ_ADDR_W:0]   buffer_count
);
    import oq_pkg::*;

    localparam logic [`OQ_ADDR_W:0] FULL_CNT = `OQ_BUF_DEPTH;

    // word storage plus one next pointer per word
    logic [`OQ_DATA_W-1:0] mem_data [`OQ_BUF_DEPTH];
    logic [`OQ_KEEP_W-1:0] mem_keep [`OQ_BUF_DEPTH];
    logic                  mem_last [`OQ_BUF_DEPTH];
    pifo_word_u            mem_tag  [`OQ_BUF_DEPTH];
    logic [`OQ_ADDR_W-1:0] link     [`OQ_BUF_DEPTH];

    // free list ends
    logic [`OQ_ADDR_W-1:0] fl_head;
    logic [`OQ_ADDR_W-1:0] fl_tail;
    logic [`OQ_ADDR_W-1:0] free_addr;
    logic                  list_drained;

    // current packet on the input
    logic                  in_pkt;
    logic                  first_word;
    logic [`OQ_ADDR_W-1:0] sop_q;
    logic [`OQ_ADDR_W-1:0] prev_q;
    pifo_word_u            tag_q;
    logic [`OQ_ADDR_W-1:0] sop_addr;
    pifo_word_u            cur_tag;

    assign first_word = s_axis_tvalid && !in_pkt;
    assign sop_addr   = first_word ? fl_head : sop_q;
    // tpifo only counts on the first word
    assign cur_tag    = first_word ? s_axis_tpifo : tag_q;

    //////////////////////////////
    // calendar insert
    //////////////////////////////

    assign insert_en = s_axis_tvalid && s_axis_tlast;

    // tag view in, entry view out
    always_comb
    begin
        insert_word.entry_view.rank = cur_tag.tag_view.rank;
        insert_word.entry_view.addr = sop_addr;
    end

    //////////////////////////////
    // free list
    //////////////////////////////

    // no free word left once this cycle's write lands
    assign list_drained = (buffer_count == FULL_CNT) ||
                          (s_axis_tvalid && buffer_count == FULL_CNT - 1'b1);

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            // every word chained behind the next one
            for (int i = 0; i < `OQ_BUF_DEPTH; i++)
            begin
                link[i] <= `OQ_ADDR_W'(i + 1);
            end
            fl_head <= '0;
            fl_tail <= `OQ_ADDR_W'(`OQ_BUF_DEPTH - 1);
        end
        else
        begin
            if (s_axis_tvalid)
            begin
                fl_head <= link[fl_head];
                // chain onto the previous word of this packet
                if (!first_word)
                begin
                    link[prev_q] <= fl_head;
                end
            end
            // word read last cycle goes back on the tail
            if (credit_return)
            begin
                if (list_drained)
                begin
                    fl_head <= free_addr;
                end
                else
                begin
                    link[fl_tail] <= free_addr;
                end
                fl_tail <= free_addr;
            end
        end
    end

    //////////////////////////////
    // control and occupancy
    //////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            in_pkt        <= 1'b0;
            credit_return <= 1'b0;
            buffer_count  <= '0;
        end
        else
        begin
            if (s_axis_tvalid)
            begin
                in_pkt <= !s_axis_tlast;
            end
            credit_return <= rd_en;
            // count drops in the cycle after the credit pulse
            case ({s_axis_tvalid, credit_return})
                2'b10:   buffer_count <= buffer_count + 1'b1;
                2'b01:   buffer_count <= buffer_count - 1'b1;
                default: buffer_count <= buffer_count;
            endcase
        end
    end

    // packet bookkeeping and the address to free
    always_ff @(posedge axis_aclk)
    begin
        if (s_axis_tvalid)
        begin
            prev_q <= fl_head;
        end
        if (first_word)
        begin
            sop_q <= fl_head;
            tag_q <= s_axis_tpifo;
        end
        if (rd_en)
        begin
            free_addr <= rd_addr;
        end
    end

    //////////////////////////////
    // word memory
    //////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (s_axis_tvalid)
        begin
            mem_data[fl_head] <= s_axis_tdata;
            mem_keep[fl_head] <= s_axis_tkeep;
            mem_last[fl_head] <= s_axis_tlast;
            mem_tag[fl_head]  <= cur_tag;
        end
        // read regs hold until the next read
        if (rd_en)
        begin
            rd_data <= mem_data[rd_addr];
            rd_keep <= mem_keep[rd_addr];
            rd_last <= mem_last[rd_addr];
            rd_tag  <= mem_tag[rd_addr];
            rd_next <= link[rd_addr];
        end
    end

endmodule

/* logic/oq_pkg.sv */
`include "oq_defs.svh"

package oq_pkg;

    //////////////////////////////
    // calendar word
    //////////////////////////////

    // view on the input and output streams
    typedef struct packed
    {
        logic [`OQ_RANK_W-1:0] rank;
        logic [`OQ_TAG_W-1:0]  tag;
    } pifo_tag_t;

    // view inside the calendar
    // low field points at the first word of the packet
    typedef struct packed
    {
        logic [`OQ_RANK_W-1:0] rank;
        logic [`OQ_ADDR_W-1:0] addr;
    } pifo_entry_t;

    // same 16 bits, decoded by whoever holds them
    typedef union packed
    {
        pifo_tag_t   tag_view;
        pifo_entry_t entry_view;
    } pifo_word_u;

endpackage

/* logic/oq_defs.svh */
`ifndef OQ_DEFS_SVH
`define OQ_DEFS_SVH

//////////////////////////////
// stream widths
//////////////////////////////

// payload word
`define OQ_DATA_W 32
// one keep bit per byte
`define OQ_KEEP_W 4

//////////////////////////////
// buffer and calendar sizing
//////////////////////////////

// words in the buffer, also calendar slots
`define OQ_BUF_DEPTH 32
`define OQ_ADDR_W 5

// calendar word, rank on top of tag or address
`define OQ_PIFO_W 16
// tag field sits where the buffer address goes
`define OQ_TAG_W `OQ_ADDR_W
// 11 bits of rank
`define OQ_RANK_W (`OQ_PIFO_W - `OQ_TAG_W)

`endif
